// ==== src/regWindowsCfg.svh ====
`ifndef REGWINDOWS_CFG_SVH
`define REGWINDOWS_CFG_SVH

// Width of one register
`define REGWIN_DATA_WIDTH 32

// Number of register windows
// Must stay a power of two so the window pointer wraps by itself
`define REGWIN_NUM_WINDOWS 4

// Registers per group (globals, outs, locals or ins)
`define REGWIN_GROUP_SIZE 8

// Logical registers seen from one window, r0 to r31
`define REGWIN_NUM_LOGICAL (4 * `REGWIN_GROUP_SIZE)

// Group codes in the top bits of a logical register number
`define REGWIN_GRP_GLOBAL 2'd0
`define REGWIN_GRP_OUT 2'd1
`define REGWIN_GRP_LOCAL 2'd2
`define REGWIN_GRP_IN 2'd3

// Physical layout is globals, then shared out/in groups, then locals
`define REGWIN_SHARED_BASE `REGWIN_GROUP_SIZE
`define REGWIN_LOCAL_BASE (`REGWIN_GROUP_SIZE * (1 + `REGWIN_NUM_WINDOWS))

// 72 physical registers in total
`define REGWIN_NUM_PHYS (`REGWIN_GROUP_SIZE * (1 + 2 * `REGWIN_NUM_WINDOWS))

`endif

// ==== src/regWinArchPkg.sv ====
`default_nettype none

`include "regWindowsCfg.svh"

package regWinArchPkg;

        //**************************************************
        // Data
        //**************************************************

        // One register value
        typedef logic [`REGWIN_DATA_WIDTH-1:0] regData_t;

        //**************************************************
        // Logical view
        //**************************************************

        // Register number as software sees it
        typedef logic [$clog2(`REGWIN_NUM_LOGICAL)-1:0] logicalIdx_t;

        // Top bits of a logical number
        // Selects globals, outs, locals or ins
        typedef logic [$clog2(`REGWIN_NUM_LOGICAL / `REGWIN_GROUP_SIZE)-1:0] regGroup_t;

        // Position inside a group
        typedef logic [$clog2(`REGWIN_GROUP_SIZE)-1:0] grpOffset_t;

        // Current window pointer
        typedef logic [$clog2(`REGWIN_NUM_WINDOWS)-1:0] cwp_t;

        //**************************************************
        // Physical view
        //**************************************************

        // Index into the bank of 72 registers
        typedef logic [$clog2(`REGWIN_NUM_PHYS)-1:0] physIdx_t;

        // One bit per physical register
        typedef logic [`REGWIN_NUM_PHYS-1:0] physMask_t;

endpackage

`default_nettype wire

// ==== src/regWinPortPkg.sv ====
`default_nettype none

package regWinPortPkg;

        //**************************************************
        // Write port
        //**************************************************

        // Single-cycle write strobe with target and payload
        typedef struct packed {
                logic wrEn;
                regWinArchPkg::logicalIdx_t wrSel;
                regWinArchPkg::regData_t wrData;
        } regWrite_t;

        //**************************************************
        // Read ports
        //**************************************************

        // Logical selects for ports A and B
        typedef struct packed {
                regWinArchPkg::logicalIdx_t selA;
                regWinArchPkg::logicalIdx_t selB;
        } regReadSel_t;

        // Combinational read results
        typedef struct packed {
                regWinArchPkg::regData_t dataA;
                regWinArchPkg::regData_t dataB;
        } regReadData_t;

endpackage

`default_nettype wire

// ==== src/windowDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "regWindowsCfg.svh"

module windowDecoder
(
        input wire regWinArchPkg::cwp_t cwp,
        input wire regWinArchPkg::logicalIdx_t wrSel,
        input wire regWinPortPkg::regReadSel_t rdSel,
        input wire clear,
        output regWinArchPkg::physIdx_t wrPhys,
        output regWinArchPkg::physIdx_t rdPhysA,
        output regWinArchPkg::physIdx_t rdPhysB,
        output regWinArchPkg::physMask_t clrMask
);

        //**************************************************
        // Logical to physical mapping
        //**************************************************

        // Same rule for the write select and both read selects
        function automatic regWinArchPkg::physIdx_t mapLogical
        (
                input regWinArchPkg::cwp_t win,
                input regWinArchPkg::logicalIdx_t sel
        );
                regWinArchPkg::regGroup_t grp;
                regWinArchPkg::grpOffset_t off;
                regWinArchPkg::cwp_t upWin;
                regWinArchPkg::physIdx_t phys;

                {grp, off} = sel;

                // Window above this one, window 3 wraps to 0
                upWin = win + 1'b1;

                case (grp)
                        `REGWIN_GRP_GLOBAL:
                                phys = regWinArchPkg::physIdx_t'(off);
                        `REGWIN_GRP_OUT:
                                phys = regWinArchPkg::physIdx_t'(`REGWIN_SHARED_BASE
                                        + `REGWIN_GROUP_SIZE * win + off);
                        `REGWIN_GRP_LOCAL:
                                phys = regWinArchPkg::physIdx_t'(`REGWIN_LOCAL_BASE
                                        + `REGWIN_GROUP_SIZE * win + off);
                        `REGWIN_GRP_IN:
                                // Ins are the outs of the next window up
                                phys = regWinArchPkg::physIdx_t'(`REGWIN_SHARED_BASE
                                        + `REGWIN_GROUP_SIZE * upWin + off);
                endcase

                return phys;
        endfunction

        assign wrPhys = mapLogical(cwp, wrSel);
        assign rdPhysA = mapLogical(cwp, rdSel.selA);
        assign rdPhysB = mapLogical(cwp, rdSel.selB);

        //**************************************************
        // Clear mask
        //**************************************************

        // Every register visible in the current window
        // Globals plus this window's outs, locals and ins
        always_comb
        begin
                clrMask = '0;
                if (clear)
                begin
                        for (int r = 0; r < `REGWIN_NUM_LOGICAL; r++)
                        begin
                                clrMask[mapLogical(cwp, regWinArchPkg::logicalIdx_t'(r))] = 1'b1;
                        end
                end
        end

        //**************************************************
        // Checks
        //**************************************************

        // Decoded indices stay inside the bank
        idxInRange: assert final ($isunknown({cwp, wrSel, rdSel})
                || (wrPhys < `REGWIN_NUM_PHYS
                && rdPhysA < `REGWIN_NUM_PHYS
                && rdPhysB < `REGWIN_NUM_PHYS))
                else $error("windowDecoder: physical index out of range");

        // No two logical registers of one window share a physical one
        clrMaskCount: assert final ($isunknown({clear, cwp}) || !clear
                || $countones(clrMask) == `REGWIN_NUM_LOGICAL)
                else $error("windowDecoder: clear mask has %0d bits set",
                        $countones(clrMask));

endmodule

`default_nettype wire

// ==== src/physRegBank.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "regWindowsCfg.svh"

module physRegBank
(
        input wire Clk,
        input wire rstN,
        input wire wrEn,
        input wire regWinArchPkg::physIdx_t wrPhys,
        input wire regWinArchPkg::regData_t wrData,
        input wire regWinArchPkg::physMask_t clrMask,
        input wire regWinArchPkg::physIdx_t rdPhysA,
        input wire regWinArchPkg::physIdx_t rdPhysB,
        output regWinPortPkg::regReadData_t rdData
);

        // Physical storage
        regWinArchPkg::regData_t regs [`REGWIN_NUM_PHYS];

        // One-hot write target
        regWinArchPkg::physMask_t wrHit;

        //**************************************************
        // Write decode
        //**************************************************

        always_comb
        begin
                wrHit = '0;
                if (wrEn)
                begin
                        wrHit[wrPhys] = 1'b1;
                end
        end

        //**************************************************
        // Register update
        //**************************************************

        // Clear has priority over a write to the same register
        always_ff @(posedge Clk or negedge rstN)
        begin
                if (!rstN)
                begin
                        for (int i = 0; i < `REGWIN_NUM_PHYS; i++)
                        begin
                                regs[i] <= '0;
                        end
                end
                else
                begin
                        for (int i = 0; i < `REGWIN_NUM_PHYS; i++)
                        begin
                                if (clrMask[i])
                                begin
                                        regs[i] <= '0;
                                end
                                else if (wrHit[i])
                                begin
                                        regs[i] <= wrData;
                                end
                        end
                end
        end

        //**************************************************
        // Read ports
        //**************************************************

        // Plain index into storage
        // A read of the register being written still sees the old value
        assign rdData = '{dataA: regs[rdPhysA], dataB: regs[rdPhysB]};

        //**************************************************
        // Checks
        //**************************************************

        // Unmasked write is stored by the next edge
        property writeLands;
                @(posedge Clk) disable iff (!rstN)
                (wrEn && !clrMask[wrPhys]) |=> (regs[$past(wrPhys)] == $past(wrData));
        endproperty

        writeLandsA: assert property (writeLands)
                else $error("physRegBank: write to register %0d not stored", $past(wrPhys));

        // Write into a register being cleared leaves it at zero
        property clearWins;
                @(posedge Clk) disable iff (!rstN)
                (wrEn && clrMask[wrPhys]) |=> (regs[$past(wrPhys)] == '0);
        endproperty

        clearWinsA: assert property (clearWins)
                else $error("physRegBank: register %0d not cleared", $past(wrPhys));

endmodule

`default_nettype wire

// ==== src/registerWindows.sv ====
`timescale 1ns/1ns
`default_nettype none

module registerWindows
(
        input wire Clk,
        input wire rstN,
        input wire regWinArchPkg::cwp_t cwp,
        input wire regWinPortPkg::regWrite_t wrReq,
        input wire clear,
        input wire regWinPortPkg::regReadSel_t rdSel,
        output regWinPortPkg::regReadData_t rdData
);

        //**************************************************
        // Decoder to bank
        //**************************************************

        // Physical write target
        regWinArchPkg::physIdx_t wrPhys;

        // Physical read targets
        regWinArchPkg::physIdx_t rdPhysA;
        regWinArchPkg::physIdx_t rdPhysB;

        // Registers zeroed by a clear strobe
        regWinArchPkg::physMask_t clrMask;

        //**************************************************
        // Window decode
        //**************************************************

        windowDecoder decoder
        (
                .cwp (cwp),
                .wrSel (wrReq.wrSel),
                .rdSel (rdSel),
                .clear (clear),
                .wrPhys (wrPhys),
                .rdPhysA (rdPhysA),
                .rdPhysB (rdPhysB),
                .clrMask (clrMask)
        );

        //**************************************************
        // Physical storage
        //**************************************************

        physRegBank regBank
        (
                .Clk (Clk),
                .rstN (rstN),
                .wrEn (wrReq.wrEn),
                .wrPhys (wrPhys),
                .wrData (wrReq.wrData),
                .clrMask (clrMask),
                .rdPhysA (rdPhysA),
                .rdPhysB (rdPhysB),
                .rdData (rdData)
        );

endmodule

`default_nettype wire

// ==== dv/registerWindowsTb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "regWindowsCfg.svh"

module registerWindowsTb;

        localparam int CLK_PERIOD = 40;
        localparam int SAMPLE_LEAD = 5;
        localparam int unsigned SEED = 32'h62cf_4069;

        // Cycle budget of each test
        localparam int RESET_CYCLES = 8;
        localparam int AFTER_RESET_CYCLES = 128;
        localparam int GLOBAL_CYCLES = 40;
        localparam int LOCAL_CYCLES = 64;
        localparam int OVERLAP_CYCLES = 64;
        localparam int CLEAR_CYCLES = 330;
        localparam int RANDOM_CYCLES = 2000;
        localparam int END_CYCLES = 3;
        localparam int TOTAL_CYCLES = RESET_CYCLES + AFTER_RESET_CYCLES + GLOBAL_CYCLES
                + LOCAL_CYCLES + OVERLAP_CYCLES + CLEAR_CYCLES + RANDOM_CYCLES + END_CYCLES;
        localparam int WATCHDOG_NS = (TOTAL_CYCLES + 100) * CLK_PERIOD;

        typedef regWinArchPkg::regData_t shadow_t [`REGWIN_NUM_PHYS];

        logic Clk;
        logic rstN;
        regWinArchPkg::cwp_t cwp;
        regWinPortPkg::regWrite_t wrReq;
        logic clear;
        regWinPortPkg::regReadSel_t rdSel;
        wire regWinPortPkg::regReadData_t rdData;

        // Expected contents of all physical registers
        shadow_t shadow;

        string testName;
        string curTest;

        registerWindows dut
        (
                .Clk (Clk),
                .rstN (rstN),
                .cwp (cwp),
                .wrReq (wrReq),
                .clear (clear),
                .rdSel (rdSel),
                .rdData (rdData)
        );

        always #(CLK_PERIOD / 2) Clk = ~Clk;

        //**************************************************
        // Reference model
        //**************************************************

        // Globals, then shared out/in groups, then locals
        function automatic int physOf(input regWinArchPkg::cwp_t win,
                input regWinArchPkg::logicalIdx_t sel);
                int grp;
                int k;
                int w;
                int phys;

                grp = int'(sel) / `REGWIN_GROUP_SIZE;
                k = int'(sel) % `REGWIN_GROUP_SIZE;
                w = int'(win);
                case (grp)
                        0: phys = k;
                        1: phys = 8 + 8 * w + k;
                        2: phys = 40 + 8 * w + k;
                        default: phys = 8 + 8 * ((w + 1) % `REGWIN_NUM_WINDOWS) + k;
                endcase
                return phys;
        endfunction

        function automatic regWinArchPkg::regData_t expectedRead(input shadow_t regs,
                input regWinArchPkg::cwp_t win, input regWinArchPkg::logicalIdx_t sel);
                return regs[physOf(win, sel)];
        endfunction

        // Applies what the DUT will store at the coming edge
        task automatic updateModel();
                if (!rstN)
                begin
                        for (int i = 0; i < `REGWIN_NUM_PHYS; i++)
                        begin
                                shadow[i] = '0;
                        end
                end
                else
                begin
                        if (wrReq.wrEn)
                        begin
                                shadow[physOf(cwp, wrReq.wrSel)] = wrReq.wrData;
                        end
                        // Clear wins over a write in the same cycle
                        if (clear)
                        begin
                                for (int r = 0; r < 32; r++)
                                begin
                                        shadow[physOf(cwp, regWinArchPkg::logicalIdx_t'(r))] = '0;
                                end
                        end
                end
        endtask

        //**************************************************
        // Compare tasks
        //**************************************************

        task automatic checkRead(input string port, input regWinArchPkg::regData_t expected,
                input regWinArchPkg::regData_t actual);
                if (actual !== expected)
                begin
                        $display("ERR %s port %s cwp %0d expected %h actual %h",
                                curTest, port, cwp, expected, actual);
                        $display("Simulation failed");
                        $fatal(1, "read data mismatch");
                end
        endtask

        task automatic checkData(input regWinPortPkg::regReadData_t expected,
                input regWinPortPkg::regReadData_t actual);
                checkRead("A", expected.dataA, actual.dataA);
                checkRead("B", expected.dataB, actual.dataB);
        endtask

        // Samples reads shortly before each rising edge
        initial
        begin
                regWinPortPkg::regReadData_t expData;

                for (int i = 0; i < `REGWIN_NUM_PHYS; i++)
                begin
                        shadow[i] = '0;
                end
                forever
                begin
                        @(posedge Clk);
                        #(CLK_PERIOD - SAMPLE_LEAD);
                        expData.dataA = expectedRead(shadow, cwp, rdSel.selA);
                        expData.dataB = expectedRead(shadow, cwp, rdSel.selB);
                        checkData(expData, rdData);
                        updateModel();
                end
        end

        //**************************************************
        // Stimulus helpers
        //**************************************************

        // One cycle of inputs, launched on the rising edge
        task automatic driveCycle(input regWinArchPkg::cwp_t w,
                input regWinPortPkg::regWrite_t req, input logic clr,
                input regWinPortPkg::regReadSel_t sel);
                @(posedge Clk);
                cwp <= w;
                wrReq <= req;
                clear <= clr;
                rdSel <= sel;
                curTest <= testName;
        endtask

        // Also reads the target, which must still show the old value
        task automatic writeReg(input int w, input int r, input regWinArchPkg::regData_t data);
                regWinPortPkg::regWrite_t req;
                regWinPortPkg::regReadSel_t sel;

                req = '{wrEn: 1'b1, wrSel: regWinArchPkg::logicalIdx_t'(r), wrData: data};
                sel = '{selA: regWinArchPkg::logicalIdx_t'(r), selB: regWinArchPkg::logicalIdx_t'(r)};
                driveCycle(regWinArchPkg::cwp_t'(w), req, 1'b0, sel);
        endtask

        task automatic readPair(input int w, input int a, input int b);
                regWinPortPkg::regReadSel_t sel;

                sel = '{selA: regWinArchPkg::logicalIdx_t'(a), selB: regWinArchPkg::logicalIdx_t'(b)};
                driveCycle(regWinArchPkg::cwp_t'(w), '0, 1'b0, sel);
        endtask

        task automatic clearWindow(input int w, input int r, input regWinArchPkg::regData_t data);
                regWinPortPkg::regWrite_t req;

                req = '{wrEn: 1'b1, wrSel: regWinArchPkg::logicalIdx_t'(r), wrData: data};
                driveCycle(regWinArchPkg::cwp_t'(w), req, 1'b1, '0);
        endtask

        // Every logical register on both ports
        task automatic readAllWindows();
                for (int w = 0; w < `REGWIN_NUM_WINDOWS; w++)
                begin
                        for (int r = 0; r < `REGWIN_NUM_LOGICAL; r++)
                        begin
                                readPair(w, r, (r + 16) % `REGWIN_NUM_LOGICAL);
                        end
                end
        endtask

        //**************************************************
        // Tests
        //**************************************************

        task automatic sharedGlobals();
                testName = "sharedGlobals";
                for (int k = 0; k < 8; k++)
                begin
                        writeReg(2, k, $urandom());
                end
                for (int w = 0; w < `REGWIN_NUM_WINDOWS; w++)
                begin
                        for (int k = 0; k < 8; k++)
                        begin
                                readPair(w, k, 7 - k);
                        end
                end
        endtask

        task automatic privateLocals();
                testName = "privateLocals";
                for (int w = 0; w < `REGWIN_NUM_WINDOWS; w++)
                begin
                        for (int k = 0; k < 8; k++)
                        begin
                                writeReg(w, 16 + k, $urandom());
                        end
                end
                for (int w = 0; w < `REGWIN_NUM_WINDOWS; w++)
                begin
                        for (int k = 0; k < 8; k++)
                        begin
                                readPair(w, 16 + k, 23 - k);
                        end
                end
        endtask

        // Ins of window 3 land in the outs of window 0
        task automatic windowOverlap();
                testName = "windowOverlap";
                for (int w = 0; w < `REGWIN_NUM_WINDOWS; w++)
                begin
                        for (int k = 0; k < 8; k++)
                        begin
                                writeReg(w, 24 + k, $urandom());
                        end
                end
                for (int w = 0; w < `REGWIN_NUM_WINDOWS; w++)
                begin
                        for (int k = 0; k < 8; k++)
                        begin
                                readPair((w + 1) % `REGWIN_NUM_WINDOWS, 8 + k, 24 + k);
                        end
                end
        endtask

        task automatic scopedClear();
                testName = "scopedClear";
                for (int k = 0; k < 8; k++)
                begin
                        writeReg(0, k, $urandom());
                end
                for (int w = 0; w < `REGWIN_NUM_WINDOWS; w++)
                begin
                        for (int k = 0; k < 8; k++)
                        begin
                                writeReg(w, 8 + k, $urandom());
                                writeReg(w, 16 + k, $urandom());
                        end
                end
                // Write into a local of the cleared window
                clearWindow(2, 17, 32'hdead_beef);
                readAllWindows();
                // Write into an in of window 3, shared with window 0
                clearWindow(3, 24, 32'h1234_5678);
                readAllWindows();
        endtask

        task automatic randomMix(input int cycles);
                regWinArchPkg::cwp_t w;
                regWinPortPkg::regWrite_t req;
                regWinPortPkg::regReadSel_t sel;
                logic clr;

                testName = "randomMix";
                w = '0;
                for (int i = 0; i < cycles; i++)
                begin
                        if ($urandom() % 8 == 0)
                        begin
                                w = regWinArchPkg::cwp_t'($urandom());
                        end
                        req.wrEn = ($urandom() % 2) == 0;
                        req.wrSel = regWinArchPkg::logicalIdx_t'($urandom());
                        req.wrData = $urandom();
                        clr = ($urandom() % 32) == 0;
                        sel.selA = regWinArchPkg::logicalIdx_t'($urandom());
                        sel.selB = regWinArchPkg::logicalIdx_t'($urandom());
                        // Same-cycle read of the target
                        if ($urandom() % 4 == 0)
                        begin
                                sel.selA = req.wrSel;
                        end
                        driveCycle(w, req, clr, sel);
                end
        endtask

        //**************************************************
        // Main sequence
        //**************************************************

        initial
        begin
                void'($urandom(SEED));
                testName = "reset";
                curTest = "reset";
                Clk = 1'b0;
                rstN = 1'b0;
                cwp = '0;
                wrReq = '0;
                clear = 1'b0;
                rdSel = '0;

                repeat (RESET_CYCLES) @(posedge Clk);
                rstN <= 1'b1;

                testName = "zeroAfterReset";
                readAllWindows();
                sharedGlobals();
                privateLocals();
                windowOverlap();
                scopedClear();
                randomMix(RANDOM_CYCLES);

                // Let the last reads be checked
                readPair(0, 0, 0);
                repeat (2) @(posedge Clk);
                $display("Simulation passed");
                $finish;
        end

        initial
        begin
                #(WATCHDOG_NS);
                $display("Watchdog expired after %0d ns, the run hung", WATCHDOG_NS);
                $display("Simulation failed");
                $fatal(1, "timeout");
        end

endmodule

`default_nettype wire

// ==== regWindows.f ====
+incdir+src
src/regWinArchPkg.sv
src/regWinPortPkg.sv
src/windowDecoder.sv
src/physRegBank.sv
src/registerWindows.sv
dv/registerWindowsTb.sv
